/* soc_pkg.sv */
`default_nettype none

package soc_pkg;

  // -------------------------------------------------
  // bus widths
  // -------------------------------------------------
  typedef logic [31:0] addr_t;  // byte address
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;  // one bit per byte lane

  // -------------------------------------------------
  // address map
  // -------------------------------------------------
  localparam addr_t RAM_BASE      = 32'h0010_0000;  // scratch ram window
  localparam int    RAM_WORDS_DEF = 64;
  localparam addr_t CRG_BASE      = 32'h0011_0000;  // clock/reset generator regs
  localparam addr_t REGION_SIZE   = 32'h0001_0000;  // each window is 64 KiB

  // crg register offsets inside its window
  localparam logic [15:0] CRG_DIV_OFS  = 16'h0000;  // packed dividers
  localparam logic [15:0] CRG_CKEN_OFS = 16'h0004;  // enable bits

  // axi response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;
  localparam logic [1:0] RESP_DECERR = 2'b11;

  // clock groups: cpu, axi, apb, i2c, imp
  localparam int NUM_DOMAINS_DEF = 5;
  localparam int DIV_W           = 4;  // bits per divider field

  // request from the port to one target
  // only one target sees valid in a given cycle
  typedef struct packed {
    logic        valid;
    logic        write;
    logic [15:0] ofs;    // word aligned offset within the window
    data_t       wdata;
    strb_t       wstrb;
  } bus_req_t;

  // target answer, one cycle after the request
  typedef struct packed {
    logic  valid;
    data_t rdata;
    logic  err;    // mapped to SLVERR by the port
  } bus_rsp_t;

endpackage

`default_nettype wire

/* soc_axil_port.sv */
`default_nettype none

module soc_axil_port (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // write address / data
  input  logic               s_awvalid_i,
  output logic               s_awready_o,
  input  soc_pkg::addr_t     s_awaddr_i,
  input  logic               s_wvalid_i,
  output logic               s_wready_o,
  input  soc_pkg::data_t     s_wdata_i,
  input  soc_pkg::strb_t     s_wstrb_i,
  // write response
  output logic               s_bvalid_o,
  input  logic               s_bready_i,
  output logic [1:0]         s_bresp_o,
  // read address / data
  input  logic               s_arvalid_i,
  output logic               s_arready_o,
  input  soc_pkg::addr_t     s_araddr_i,
  output logic               s_rvalid_o,
  input  logic               s_rready_i,
  output soc_pkg::data_t     s_rdata_o,
  output logic [1:0]         s_rresp_o,
  // targets
  output soc_pkg::bus_req_t  ram_req_o,
  input  soc_pkg::bus_rsp_t  ram_rsp_i,
  output soc_pkg::bus_req_t  crg_req_o,
  input  soc_pkg::bus_rsp_t  crg_rsp_i
);

  typedef enum logic [1:0] {
    ST_IDLE,    // ready for a new transaction
    ST_WAIT,    // request issued, waiting for target
    ST_RESP_W,  // holding B
    ST_RESP_R   // holding R
  } state_e;

  state_e             state_q;
  logic               is_idle;
  logic               acc_wr;     // aw+w handshake this cycle
  logic               acc_rd;     // ar handshake this cycle
  logic               accept;
  soc_pkg::addr_t     acc_addr;
  logic               hit_ram;
  logic               hit_crg;
  soc_pkg::bus_req_t  req_q;      // shared payload for both targets
  logic               ram_vld_q;
  logic               crg_vld_q;
  logic               sel_ram_q;  // which target answers
  logic               dec_err_q;  // no target, answer locally
  logic               wait_ph_q;  // second wait cycle, used on decode error
  soc_pkg::bus_rsp_t  tgt_rsp;
  logic               tgt_done;
  logic [1:0]         resp_q;
  soc_pkg::data_t     rdata_q;

  // -------------------------------------------------
  // handshake and region decode
  // -------------------------------------------------
  assign is_idle = (state_q == ST_IDLE);
  assign acc_wr  = is_idle & s_awvalid_i & s_wvalid_i;  // aw and w taken together
  assign acc_rd  = is_idle & s_arvalid_i & ~s_awvalid_i & ~s_wvalid_i;  // writes first
  assign accept  = acc_wr | acc_rd;

  assign s_awready_o = acc_wr;
  assign s_wready_o  = acc_wr;
  assign s_arready_o = acc_rd;

  assign acc_addr = acc_wr ? s_awaddr_i : s_araddr_i;

  assign hit_ram = (acc_addr >= soc_pkg::RAM_BASE) &&
                   (acc_addr <  soc_pkg::RAM_BASE + soc_pkg::REGION_SIZE);
  assign hit_crg = (acc_addr >= soc_pkg::CRG_BASE) &&
                   (acc_addr <  soc_pkg::CRG_BASE + soc_pkg::REGION_SIZE);

  // answer from the selected target
  assign tgt_rsp  = sel_ram_q ? ram_rsp_i : crg_rsp_i;
  // decode error fakes the target latency so timing is identical
  assign tgt_done = dec_err_q ? wait_ph_q : tgt_rsp.valid;

  // -------------------------------------------------
  // control fsm
  // -------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= ST_IDLE;
      ram_vld_q <= 1'b0;
      crg_vld_q <= 1'b0;
      sel_ram_q <= 1'b0;
      dec_err_q <= 1'b0;
      wait_ph_q <= 1'b0;
    end else begin
      ram_vld_q <= 1'b0;  // requests are single cycle
      crg_vld_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          wait_ph_q <= 1'b0;
          if (accept) begin
            ram_vld_q <= hit_ram;
            crg_vld_q <= hit_crg;
            sel_ram_q <= hit_ram;
            dec_err_q <= ~hit_ram & ~hit_crg;
            state_q   <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          wait_ph_q <= 1'b1;
          if (tgt_done) begin
            state_q <= req_q.write ? ST_RESP_W : ST_RESP_R;
          end
        end
        ST_RESP_W: if (s_bready_i) state_q <= ST_IDLE;  // master took B
        ST_RESP_R: if (s_rready_i) state_q <= ST_IDLE;  // master took R
        default:   state_q <= ST_IDLE;
      endcase
    end
  end

  // -------------------------------------------------
  // payload capture
  // -------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q.valid <= 1'b0;  // per target valid is merged at the outputs
      req_q.write <= acc_wr;
      req_q.ofs   <= {acc_addr[15:2], 2'b00};  // byte lanes come from strobes
      req_q.wdata <= s_wdata_i;
      req_q.wstrb <= acc_wr ? s_wstrb_i : '0;
    end
    if ((state_q == ST_WAIT) && tgt_done) begin
      if (dec_err_q) begin
        resp_q  <= soc_pkg::RESP_DECERR;
        rdata_q <= '0;
      end else begin
        resp_q  <= tgt_rsp.err ? soc_pkg::RESP_SLVERR : soc_pkg::RESP_OKAY;
        rdata_q <= tgt_rsp.rdata;
      end
    end
  end

  always_comb begin
    ram_req_o       = req_q;
    ram_req_o.valid = ram_vld_q;
    crg_req_o       = req_q;
    crg_req_o.valid = crg_vld_q;
  end

  // responses held stable until the master takes them
  assign s_bvalid_o = (state_q == ST_RESP_W);
  assign s_bresp_o  = resp_q;
  assign s_rvalid_o = (state_q == ST_RESP_R);
  assign s_rresp_o  = resp_q;
  assign s_rdata_o  = rdata_q;

endmodule

`default_nettype wire

/* soc_scratch_ram.sv */
`default_nettype none

module soc_scratch_ram #(
  parameter int RAM_WORDS = soc_pkg::RAM_WORDS_DEF
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  soc_pkg::bus_req_t  req_i,
  output soc_pkg::bus_rsp_t  rsp_o
);

  localparam int IDX_W  = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;
  localparam int NBYTES = $bits(soc_pkg::strb_t);

  soc_pkg::data_t  mem [RAM_WORDS];
  logic [13:0]     word;     // word number inside the 64 KiB window
  logic [IDX_W-1:0] idx;
  logic            vld_q;
  soc_pkg::data_t  rdata_q;

  assign word = req_i.ofs[15:2];
  assign idx  = IDX_W'(word % 14'(RAM_WORDS));  // aliases past the depth

  // -------------------------------------------------
  // storage, byte lane writes
  // -------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (req_i.valid && req_i.write) begin
      for (int b = 0; b < NBYTES; b++) begin
        if (req_i.wstrb[b]) begin
          mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
    if (req_i.valid) begin
      rdata_q <= mem[idx];  // old word, only used on reads
    end
  end

  // answer one cycle after the request
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= req_i.valid;
    end
  end

  always_comb begin
    rsp_o.valid = vld_q;
    rsp_o.rdata = rdata_q;
    rsp_o.err   = 1'b0;  // every offset maps somewhere
  end

endmodule

`default_nettype wire

/* soc_crg_regs.sv */
`default_nettype none

module soc_crg_regs #(
  parameter  int NUM_DOMAINS = soc_pkg::NUM_DOMAINS_DEF,
  localparam int CFG_W       = NUM_DOMAINS * (soc_pkg::DIV_W + 1)
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  soc_pkg::bus_req_t  req_i,
  output soc_pkg::bus_rsp_t  rsp_o,
  output logic [CFG_W-1:0]   cfg_o
);

  localparam int DIV_BITS = NUM_DOMAINS * soc_pkg::DIV_W;  // must fit one word

  // dividers above, enable bits in the low end
  typedef struct packed {
    logic [NUM_DOMAINS-1:0][soc_pkg::DIV_W-1:0] div;
    logic [NUM_DOMAINS-1:0]                     cken;
  } crg_cfg_t;

  crg_cfg_t        cfg_q;
  logic            hit_div;
  logic            hit_cken;
  soc_pkg::data_t  rd_word;
  logic            vld_q;
  logic            err_q;
  soc_pkg::data_t  rdata_q;

  assign hit_div  = (req_i.ofs == soc_pkg::CRG_DIV_OFS);
  assign hit_cken = (req_i.ofs == soc_pkg::CRG_CKEN_OFS);

  // readback, upper bits zero
  always_comb begin
    rd_word = '0;
    if (hit_div)  rd_word = soc_pkg::data_t'(cfg_q.div);
    if (hit_cken) rd_word = soc_pkg::data_t'(cfg_q.cken);
  end

  // -------------------------------------------------
  // control registers
  // -------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg_q.div  <= '0;  // full speed
      cfg_q.cken <= '1;  // every group running
      vld_q      <= 1'b0;
    end else begin
      vld_q <= req_i.valid;
      if (req_i.valid && req_i.write) begin
        // strobes ignored, whole field written
        if (hit_div)  cfg_q.div  <= req_i.wdata[DIV_BITS-1:0];
        if (hit_cken) cfg_q.cken <= req_i.wdata[NUM_DOMAINS-1:0];
      end
    end
  end

  // response payload
  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      err_q   <= ~hit_div & ~hit_cken;  // unknown offset, nothing written
      rdata_q <= rd_word;
    end
  end

  always_comb begin
    rsp_o.valid = vld_q;
    rsp_o.rdata = rdata_q;
    rsp_o.err   = err_q;
  end

  assign cfg_o = cfg_q;

endmodule

`default_nettype wire

/* soc_clk_en_gen.sv */
`default_nettype none

module soc_clk_en_gen #(
  parameter  int NUM_DOMAINS = soc_pkg::NUM_DOMAINS_DEF,
  localparam int CFG_W       = NUM_DOMAINS * (soc_pkg::DIV_W + 1)
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic [CFG_W-1:0]        cfg_i,
  output logic [NUM_DOMAINS-1:0]  clk_en_o
);

  // same layout as the crg register block
  typedef struct packed {
    logic [NUM_DOMAINS-1:0][soc_pkg::DIV_W-1:0] div;
    logic [NUM_DOMAINS-1:0]                     cken;
  } crg_cfg_t;

  crg_cfg_t                                   cfg;
  crg_cfg_t                                   cfg_q;  // last seen settings
  logic [NUM_DOMAINS-1:0]                     chg;
  logic [NUM_DOMAINS-1:0][soc_pkg::DIV_W-1:0] cnt_q;
  logic [NUM_DOMAINS-1:0]                     en_q;

  assign cfg = crg_cfg_t'(cfg_i);

  // a new divider or enable restarts that group only
  always_comb begin
    for (int d = 0; d < NUM_DOMAINS; d++) begin
      chg[d] = (cfg.div[d] != cfg_q.div[d]) || (cfg.cken[d] != cfg_q.cken[d]);
    end
  end

  // -------------------------------------------------
  // per group divider, period div+1
  // -------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg_q.div  <= '0;
      cfg_q.cken <= '1;
      cnt_q      <= '0;
      en_q       <= '0;
    end else begin
      cfg_q <= cfg;
      for (int d = 0; d < NUM_DOMAINS; d++) begin
        if (chg[d]) begin
          cnt_q[d] <= '0;
          en_q[d]  <= 1'b0;
        end else if (cnt_q[d] == cfg_q.div[d]) begin
          cnt_q[d] <= '0;
          en_q[d]  <= cfg_q.cken[d];  // gated off keeps it low
        end else begin
          cnt_q[d] <= cnt_q[d] + 1'b1;
          en_q[d]  <= 1'b0;
        end
      end
    end
  end

  assign clk_en_o = en_q;

endmodule

`default_nettype wire

/* soc_ctrl_top.sv */
`default_nettype none

module soc_ctrl_top #(
  parameter int NUM_DOMAINS = soc_pkg::NUM_DOMAINS_DEF,
  parameter int RAM_WORDS   = soc_pkg::RAM_WORDS_DEF
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    s_awvalid_i,
  output logic                    s_awready_o,
  input  soc_pkg::addr_t          s_awaddr_i,
  input  logic                    s_wvalid_i,
  output logic                    s_wready_o,
  input  soc_pkg::data_t          s_wdata_i,
  input  soc_pkg::strb_t          s_wstrb_i,
  output logic                    s_bvalid_o,
  input  logic                    s_bready_i,
  output logic [1:0]              s_bresp_o,
  input  logic                    s_arvalid_i,
  output logic                    s_arready_o,
  input  soc_pkg::addr_t          s_araddr_i,
  output logic                    s_rvalid_o,
  input  logic                    s_rready_i,
  output soc_pkg::data_t          s_rdata_o,
  output logic [1:0]              s_rresp_o,
  output logic [NUM_DOMAINS-1:0]  clk_en_o
);

  localparam int CFG_W = NUM_DOMAINS * (soc_pkg::DIV_W + 1);

  soc_pkg::bus_req_t  ram_req;
  soc_pkg::bus_rsp_t  ram_rsp;
  soc_pkg::bus_req_t  crg_req;
  soc_pkg::bus_rsp_t  crg_rsp;
  logic [CFG_W-1:0]   crg_cfg;  // dividers and enables

  // -------------------------------------------------
  // axi-lite slave and decoder
  // -------------------------------------------------
  soc_axil_port u0_axil_port (
    .clk_i        ( clk_i       ),
    .rst_n_i      ( rst_n_i     ),
    .s_awvalid_i  ( s_awvalid_i ),
    .s_awready_o  ( s_awready_o ),
    .s_awaddr_i   ( s_awaddr_i  ),
    .s_wvalid_i   ( s_wvalid_i  ),
    .s_wready_o   ( s_wready_o  ),
    .s_wdata_i    ( s_wdata_i   ),
    .s_wstrb_i    ( s_wstrb_i   ),
    .s_bvalid_o   ( s_bvalid_o  ),
    .s_bready_i   ( s_bready_i  ),
    .s_bresp_o    ( s_bresp_o   ),
    .s_arvalid_i  ( s_arvalid_i ),
    .s_arready_o  ( s_arready_o ),
    .s_araddr_i   ( s_araddr_i  ),
    .s_rvalid_o   ( s_rvalid_o  ),
    .s_rready_i   ( s_rready_i  ),
    .s_rdata_o    ( s_rdata_o   ),
    .s_rresp_o    ( s_rresp_o   ),
    .ram_req_o    ( ram_req     ),
    .ram_rsp_i    ( ram_rsp     ),
    .crg_req_o    ( crg_req     ),
    .crg_rsp_i    ( crg_rsp     )
  );

  // -------------------------------------------------
  // targets
  // -------------------------------------------------
  soc_scratch_ram #(
    .RAM_WORDS    ( RAM_WORDS   )
  ) u0_scratch_ram (
    .clk_i        ( clk_i       ),
    .rst_n_i      ( rst_n_i     ),
    .req_i        ( ram_req     ),  // 0x0010_0000
    .rsp_o        ( ram_rsp     )
  );

  soc_crg_regs #(
    .NUM_DOMAINS  ( NUM_DOMAINS )
  ) u0_crg_regs (
    .clk_i        ( clk_i       ),
    .rst_n_i      ( rst_n_i     ),
    .req_i        ( crg_req     ),  // 0x0011_0000
    .rsp_o        ( crg_rsp     ),
    .cfg_o        ( crg_cfg     )
  );

  // clock group enables
  soc_clk_en_gen #(
    .NUM_DOMAINS  ( NUM_DOMAINS )
  ) u0_clk_en_gen (
    .clk_i        ( clk_i       ),
    .rst_n_i      ( rst_n_i     ),
    .cfg_i        ( crg_cfg     ),
    .clk_en_o     ( clk_en_o    )
  );

endmodule

`default_nettype wire

/* tb_soc_checker.sv */
`default_nettype none

module tb_soc_checker (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        s_awready_o,
  input  logic        s_wready_o,
  input  logic        s_bvalid_o,
  input  logic        s_bready_i,
  input  logic [1:0]  s_bresp_o,
  input  logic        s_rvalid_o,
  input  logic        s_rready_i,
  input  logic [31:0] s_rdata_o
);

  int fail_cnt = 0;  // failed assertions so far

  // -------------------------------------------------
  // response channels hold until taken
  // -------------------------------------------------
  a_b_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    s_bvalid_o && !s_bready_i |=> s_bvalid_o && $stable(s_bresp_o))
    else begin
      $error("bvalid or bresp changed before bready");
      fail_cnt++;
    end

  a_r_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    s_rvalid_o && !s_rready_i |=> s_rvalid_o && $stable(s_rdata_o))
    else begin
      $error("rvalid or rdata changed before rready");
      fail_cnt++;
    end

  // aw and w are always taken together
  a_aw_w: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    s_awready_o == s_wready_o)
    else begin
      $error("awready and wready differ");
      fail_cnt++;
    end

  a_one_resp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(s_bvalid_o && s_rvalid_o))
    else begin
      $error("bvalid and rvalid high together");
      fail_cnt++;
    end

endmodule

`default_nettype wire

/* tb_soc_monitor.sv */
`default_nettype none

module tb_soc_monitor (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        bvalid_i,
  input  logic        bready_i,
  input  logic [1:0]  bresp_i,
  input  logic        rvalid_i,
  input  logic        rready_i,
  input  logic [31:0] rdata_i,
  input  logic [1:0]  rresp_i,
  input  logic [4:0]  clk_en_i,
  input  logic        exp_push_i,   // one expectation per transaction
  input  logic        exp_rd_i,
  input  logic [31:0] exp_rdata_i,
  input  logic [1:0]  exp_resp_i,
  input  logic        all_high_i,   // every enable must be high
  input  logic        win_i,        // pulse counting window
  input  logic [19:0] exp_div_i,
  input  logic [4:0]  exp_cken_i,
  output int          err_cnt_o,
  output int          chk_cnt_o
);

  typedef struct packed {
    logic        is_rd;
    logic [31:0] rdata;
    logic [1:0]  resp;
  } exp_t;

  exp_t exp_q[$];
  exp_t e;
  int   pulses[5];
  int   win_cyc;
  int   want;
  logic win_q;

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      win_q   <= 1'b0;
      win_cyc = 0;
    end else begin
      if (exp_push_i) exp_q.push_back('{exp_rd_i, exp_rdata_i, exp_resp_i});
      // ------------------------------------------------
      // write and read responses
      // ------------------------------------------------
      if (bvalid_i && bready_i) begin
        chk_cnt_o++;
        if (exp_q.size() == 0) begin
          $display("unexpected write response with nothing outstanding");
          err_cnt_o++;
        end else begin
          e = exp_q.pop_front();
          if (e.is_rd || bresp_i != e.resp) begin
            $display("ERROR @%0t: bresp %0d, expected %0d", $time, bresp_i, e.resp);
            err_cnt_o++;
          end
        end
      end
      if (rvalid_i && rready_i) begin
        chk_cnt_o++;
        if (exp_q.size() == 0) begin
          $display("unexpected read response with nothing outstanding");
          err_cnt_o++;
        end else begin
          e = exp_q.pop_front();
          if (!e.is_rd || rresp_i != e.resp || rdata_i != e.rdata) begin
            $display("ERROR @%0t: read %h/%0d, expected %h/%0d", $time,
                     rdata_i, rresp_i, e.rdata, e.resp);
            err_cnt_o++;
          end
        end
      end
      if (all_high_i && clk_en_i != 5'h1f) begin  // reset defaults, full speed
        $display("ERROR @%0t: clk_en %b, expected all high", $time, clk_en_i);
        err_cnt_o++;
      end
      // ------------------------------------------------
      // pulse counting
      // ------------------------------------------------
      win_q <= win_i;
      if (win_i && !win_q) begin
        win_cyc = 0;
        for (int d = 0; d < 5; d++) pulses[d] = 0;
      end
      if (win_i) begin
        win_cyc++;
        for (int d = 0; d < 5; d++) if (clk_en_i[d]) pulses[d]++;
      end
      if (!win_i && win_q) begin  // window closed, judge counts
        for (int d = 0; d < 5; d++) begin
          want = exp_cken_i[d] ? win_cyc / (int'(exp_div_i[4*d +: 4]) + 1) : 0;
          chk_cnt_o++;
          if (pulses[d] > want + 1 || pulses[d] < want - 1 ||
              (!exp_cken_i[d] && pulses[d] != 0)) begin
            $display("ERROR @%0t: domain %0d gave %0d pulses, expected %0d",
                     $time, d, pulses[d], want);
            err_cnt_o++;
          end
        end
      end
    end
  end

  initial begin
    err_cnt_o = 0;
    chk_cnt_o = 0;
  end

endmodule

`default_nettype wire

/* tb_soc_ctrl.sv */
`default_nettype none

module tb_soc_ctrl;

  localparam int N_TXN     = 2 + 10 + 7 + 3 + 200;  // transactions over all tests
  localparam int LIMIT_CYC = N_TXN * 50 + 2000;

  logic clk = 1'b0;
  logic rst_n;
  logic awvalid, wvalid, bready, arvalid, rready;
  logic awready, wready, bvalid, arready, rvalid;
  soc_pkg::addr_t awaddr, araddr;
  soc_pkg::data_t wdata, rdata;
  soc_pkg::strb_t wstrb;
  logic [1:0] bresp, rresp;
  logic [4:0] clk_en;
  logic        exp_push, exp_rd, all_high, win;
  logic [31:0] exp_rdata;
  logic [1:0]  exp_resp;
  int          err_cnt, chk_cnt, err_start, tests_run;

  // reference model state
  logic [31:0] ram_m[64];
  logic        ram_ok[64];  // word fully written once
  logic [19:0] div_m;
  logic [4:0]  cken_m;

  always #10 clk = ~clk;

  soc_ctrl_top u_soc_ctrl_top (
    .clk_i(clk), .rst_n_i(rst_n),
    .s_awvalid_i(awvalid), .s_awready_o(awready), .s_awaddr_i(awaddr),
    .s_wvalid_i(wvalid), .s_wready_o(wready), .s_wdata_i(wdata), .s_wstrb_i(wstrb),
    .s_bvalid_o(bvalid), .s_bready_i(bready), .s_bresp_o(bresp),
    .s_arvalid_i(arvalid), .s_arready_o(arready), .s_araddr_i(araddr),
    .s_rvalid_o(rvalid), .s_rready_i(rready), .s_rdata_o(rdata), .s_rresp_o(rresp),
    .clk_en_o(clk_en)
  );

  tb_soc_monitor u_monitor (
    .clk_i(clk), .rst_n_i(rst_n),
    .bvalid_i(bvalid), .bready_i(bready), .bresp_i(bresp),
    .rvalid_i(rvalid), .rready_i(rready), .rdata_i(rdata), .rresp_i(rresp),
    .clk_en_i(clk_en), .exp_push_i(exp_push), .exp_rd_i(exp_rd),
    .exp_rdata_i(exp_rdata), .exp_resp_i(exp_resp), .all_high_i(all_high),
    .win_i(win), .exp_div_i(div_m), .exp_cken_i(cken_m),
    .err_cnt_o(err_cnt), .chk_cnt_o(chk_cnt)
  );

  bind soc_axil_port tb_soc_checker u_checker (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .s_awready_o(s_awready_o),
    .s_wready_o(s_wready_o), .s_bvalid_o(s_bvalid_o), .s_bready_i(s_bready_i),
    .s_bresp_o(s_bresp_o), .s_rvalid_o(s_rvalid_o), .s_rready_i(s_rready_i),
    .s_rdata_o(s_rdata_o)
  );

  // expected rdata and response for one access, updates the model
  function automatic void ref_access(input logic wr, input logic [31:0] a,
      input logic [31:0] d, input logic [3:0] s,
      output logic [31:0] rd, output logic [1:0] rsp);
    int idx;
    rd  = '0;
    rsp = 2'd0;
    if (a >= 32'h0010_0000 && a < 32'h0011_0000) begin
      idx = int'(a[15:2]) % 64;  // ram aliases past its depth
      if (wr) begin
        for (int b = 0; b < 4; b++) if (s[b]) ram_m[idx][8*b +: 8] = d[8*b +: 8];
        ram_ok[idx] = 1'b1;
      end else begin
        rd = ram_m[idx];
      end
    end else if (a >= 32'h0011_0000 && a < 32'h0012_0000) begin
      case ({a[15:2], 2'b00})
        16'h0: begin
          if (wr) div_m = d[19:0];
          else    rd = {12'h0, div_m};
        end
        16'h4: begin
          if (wr) cken_m = d[4:0];
          else    rd = {27'h0, cken_m};
        end
        default: rsp = 2'd2;  // slave error, nothing written
      endcase
    end else begin
      rsp = 2'd3;
    end
  endfunction

  // -------------------------------------------------
  // bus tasks, entered and left on a rising edge
  // -------------------------------------------------
  task automatic axi_write(input logic [31:0] a, input logic [31:0] d,
      input logic [3:0] s, input int dly);
    logic [31:0] rd;
    logic [1:0]  rsp;
    ref_access(1'b1, a, d, s, rd, rsp);
    exp_push <= 1'b1;
    exp_rd <= 1'b0;
    exp_rdata <= rd;
    exp_resp <= rsp;
    awvalid <= 1'b1;
    awaddr <= a;
    wvalid <= 1'b1;
    wdata <= d;
    wstrb <= s;
    @(posedge clk);
    exp_push <= 1'b0;
    while (!(awready && wready)) @(posedge clk);
    awvalid <= 1'b0;
    wvalid <= 1'b0;
    while (!bvalid) @(posedge clk);
    repeat (dly) @(posedge clk);  // back-pressure
    bready <= 1'b1;
    @(posedge clk);
    bready <= 1'b0;
  endtask

  task automatic axi_read(input logic [31:0] a, input int dly);
    logic [31:0] rd;
    logic [1:0]  rsp;
    ref_access(1'b0, a, '0, '0, rd, rsp);
    exp_push <= 1'b1;
    exp_rd <= 1'b1;
    exp_rdata <= rd;
    exp_resp <= rsp;
    arvalid <= 1'b1;
    araddr <= a;
    @(posedge clk);
    exp_push <= 1'b0;
    while (!arready) @(posedge clk);
    arvalid <= 1'b0;
    while (!rvalid) @(posedge clk);
    repeat (dly) @(posedge clk);
    rready <= 1'b1;
    @(posedge clk);
    rready <= 1'b0;
  endtask

  task automatic report_test(input string name);
    tests_run++;
    $display("%s: %s", name, (err_cnt == err_start) ? "ok" : "FAIL");
    err_start = err_cnt;
  endtask

  initial begin
    int kind;
    int w;
    int dly;
    int n_err;
    logic [31:0] d;
    void'($urandom(80));
    {awvalid, wvalid, bready, arvalid, rready} = '0;
    awaddr = '0;
    araddr = '0;
    wdata = '0;
    wstrb = '0;
    {exp_push, exp_rd, all_high, win} = '0;
    exp_rdata = '0;
    exp_resp = '0;
    err_start = 0;
    tests_run = 0;
    div_m = '0;
    cken_m = 5'h1f;
    for (int i = 0; i < 64; i++) begin
      ram_m[i] = '0;
      ram_ok[i] = 1'b0;
    end
    rst_n = 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    // 1: reset values, enables running at full rate
    repeat (2) @(posedge clk);
    all_high <= 1'b1;
    axi_read(32'h0011_0000, 0);
    axi_read(32'h0011_0004, 0);
    all_high <= 1'b0;
    report_test("reset values");

    // 2: ram strobes and aliasing
    axi_write(32'h0010_0000, 32'h1122_3344, 4'hf, 0);
    axi_write(32'h0010_0004, 32'ha5a5_a5a5, 4'hf, 1);
    axi_write(32'h0010_0000, 32'hdead_beef, 4'b0101, 0);
    axi_write(32'h0010_0004, 32'h0bad_f00d, 4'b1000, 2);
    axi_write(32'h0010_0000 + 69 * 4, 32'hcafe_0001, 4'hf, 0);  // word 5
    axi_write(32'h0010_0014, 32'h0000_7700, 4'b0010, 0);
    axi_read(32'h0010_0000, 0);
    axi_read(32'h0010_0004, 3);
    axi_read(32'h0010_0014, 0);
    axi_read(32'h0010_0000 + 69 * 4, 1);
    report_test("ram strobes");

    // 3: decode and slave errors leave state alone
    axi_write(32'h0020_0000, 32'hffff_ffff, 4'hf, 0);
    axi_read(32'h0020_0000, 0);
    axi_write(32'h0011_0008, 32'hffff_ffff, 4'hf, 0);
    axi_read(32'h0011_0008, 0);
    axi_read(32'h0011_0000, 0);
    axi_read(32'h0011_0004, 0);
    axi_read(32'h0010_0000, 0);
    report_test("error responses");

    // 4: dividers cpu 0, axi 1, apb 3, i2c 2, imp 7, i2c gated
    axi_write(32'h0011_0000, 32'h0007_2310, 4'hf, 0);
    axi_write(32'h0011_0004, 32'h0000_0017, 4'hf, 0);
    axi_read(32'h0011_0000, 0);
    repeat (4) @(posedge clk);
    win <= 1'b1;
    repeat (160) @(posedge clk);
    win <= 1'b0;
    repeat (2) @(posedge clk);
    report_test("clock enables");

    // 5: random traffic with back-pressure
    for (int i = 0; i < 200; i++) begin
      kind = $urandom_range(0, 3);
      dly = $urandom_range(0, 3);
      d = $urandom;
      if (kind < 3) begin
        w = $urandom_range(0, 127);
        if ($urandom_range(0, 1) == 1 || !ram_ok[w % 64]) begin
          axi_write(32'h0010_0000 + w * 4, d,
                    ram_ok[w % 64] ? 4'($urandom_range(0, 15)) : 4'hf, dly);
        end else begin
          axi_read(32'h0010_0000 + w * 4, dly);
        end
      end else begin
        w = $urandom_range(0, 2) * 4;  // div, cken or a hole
        if ($urandom_range(0, 1) == 1) axi_write(32'h0011_0000 + w, d, 4'hf, dly);
        else                           axi_read(32'h0011_0000 + w, dly);
      end
    end
    report_test("random traffic");

    repeat (4) @(posedge clk);
    n_err = err_cnt + u_soc_ctrl_top.u0_axil_port.u_checker.fail_cnt;
    $display("tests %0d, checks %0d, errors %0d", tests_run, chk_cnt, n_err);
    if (n_err == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // hang guard
  initial begin
    #(LIMIT_CYC * 20);
    $display("timeout: a transaction never completed, the run is stuck");
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
soc_pkg.sv
soc_axil_port.sv
soc_scratch_ram.sv
soc_crg_regs.sv
soc_clk_en_gen.sv
soc_ctrl_top.sv
tb_soc_checker.sv
tb_soc_monitor.sv
tb_soc_ctrl.sv

/* Makefile */
SRCS := $(shell cat build.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_soc_ctrl: $(SRCS) build.f
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module tb_soc_ctrl -f build.f -Mdir obj_dir

run: obj_dir/Vtb_soc_ctrl
	./obj_dir/Vtb_soc_ctrl | tee /dev/stderr | grep -qx "test passed"

clean:
	rm -rf obj_dir
